// ==== project.f ====
hdl/proc_pkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/proc.sv
bench/proc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the pipeline testbench with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module proc_tb -o proc_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/proc_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" "$log"; then
    exit 0
fi
exit 1

// ==== bench/proc_tb.sv ====
// testbench for the five-stage pipeline, program table checked against an ISA reference model
module proc_tb
    import proc_pkg::*;
();

    localparam int clk_period  = 100;
    localparam int reset_hold  = 16;
    localparam int prog_len    = 34;
    localparam int timeout_cyc = 4 * prog_len + 40;
    localparam int quiet_cyc   = 10;

    // one program slot with the retire record it should produce
    typedef struct packed {
        logic [data_width-1:0] instr;
        logic                  rand_imm;
        logic                  wr_en;
        logic [reg_aw-1:0]     wr_reg;
        logic [data_width-1:0] wr_data;
        logic                  halt;
    } entry_t;

    logic                  clk;
    logic                  reset;
    logic                  imem_we;
    logic [imem_aw-1:0]    imem_addr;
    logic [data_width-1:0] imem_data;
    retire_t               retire;
    logic                  err;

    entry_t      prog [prog_len];
    int          expect_q [$];
    logic [31:0] lfsr;
    int          errors;
    int          checks;

    proc dut (
        .clk       (clk),
        .reset     (reset),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire    (retire),
        .err       (err)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    //////////////////////////////////////////////////
    // encoding and random immediates
    function automatic logic [15:0] enc_r(input logic [2:0] fn, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [2:0] rt);
        return {op_rtype, rd, rs, rt, fn};
    endfunction

    function automatic logic [15:0] enc_i(input logic [3:0] op, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [5:0] imm);
        return {op, rd, rs, imm};
    endfunction

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_imm6(output logic [5:0] v);
        for (int b = 0; b < 6; b++) begin
            v[b] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic compare(input string name, input logic [15:0] got, input logic [15:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, want);
        end
    endtask

    task automatic set_entry(input int idx, input logic [15:0] word, input logic rnd);
        prog[idx]          = '0;
        prog[idx].instr    = word;
        prog[idx].rand_imm = rnd;
    endtask

    //////////////////////////////////////////////////
    // program table
    task automatic build_program(input logic with_illegal);
        logic [15:0] nop_w;
        logic [5:0]  r;
        nop_w = {op_nop, 12'h000};
        set_entry(0,  enc_i(op_addi, 3'd1, 3'd0, 6'h00), 1'b1);
        set_entry(1,  enc_i(op_addi, 3'd2, 3'd0, 6'h00), 1'b1);
        set_entry(2,  enc_i(op_addi, 3'd3, 3'd0, 6'h3b), 1'b0);
        set_entry(3,  nop_w, 1'b0);
        set_entry(4,  enc_r(fn_add, 3'd4, 3'd1, 3'd2), 1'b0);
        set_entry(5,  enc_r(fn_sub, 3'd5, 3'd1, 3'd2), 1'b0);
        set_entry(6,  enc_r(fn_and, 3'd6, 3'd1, 3'd3), 1'b0);
        set_entry(7,  enc_r(fn_xor, 3'd7, 3'd2, 3'd3), 1'b0);
        set_entry(8,  enc_r(fn_slt, 3'd4, 3'd3, 3'd1), 1'b0);
        set_entry(9,  enc_i(op_addi, 3'd5, 3'd3, 6'h20), 1'b0);
        set_entry(10, enc_r(fn_slt, 3'd6, 3'd1, 3'd3), 1'b0);
        // stores to words 5 and 9, word 7 stays untouched
        set_entry(11, enc_i(op_st, 3'd7, 3'd0, 6'd5), 1'b0);
        set_entry(12, enc_i(op_st, 3'd5, 3'd0, 6'd9), 1'b0);
        set_entry(13, nop_w, 1'b0);
        set_entry(14, enc_i(op_ld, 3'd1, 3'd0, 6'd5), 1'b0);
        set_entry(15, enc_i(op_ld, 3'd2, 3'd0, 6'd7), 1'b0);
        set_entry(16, enc_i(op_ld, 3'd3, 3'd0, 6'd9), 1'b0);
        // opcode 4'h8 has no meaning
        set_entry(17, with_illegal ? 16'h8000 : nop_w, 1'b0);
        set_entry(18, enc_i(op_addi, 3'd4, 3'd0, 6'd0), 1'b0);
        set_entry(19, nop_w, 1'b0);
        set_entry(20, nop_w, 1'b0);
        // taken beqz to 25, slots 22 to 24 must not write r6
        set_entry(21, enc_i(op_beqz, 3'd0, 3'd4, 6'd3), 1'b0);
        set_entry(22, enc_i(op_addi, 3'd6, 3'd0, 6'd1), 1'b0);
        set_entry(23, enc_i(op_addi, 3'd6, 3'd0, 6'd2), 1'b0);
        set_entry(24, enc_i(op_addi, 3'd6, 3'd0, 6'd3), 1'b0);
        set_entry(25, enc_i(op_bnez, 3'd0, 3'd3, 6'd2), 1'b0);
        set_entry(26, enc_i(op_addi, 3'd6, 3'd0, 6'd4), 1'b0);
        set_entry(27, enc_i(op_addi, 3'd6, 3'd0, 6'd5), 1'b0);
        // both fall through
        set_entry(28, enc_i(op_beqz, 3'd0, 3'd3, 6'd5), 1'b0);
        set_entry(29, enc_i(op_bnez, 3'd0, 3'd4, 6'd5), 1'b0);
        set_entry(30, enc_i(op_addi, 3'd6, 3'd0, 6'h00), 1'b1);
        set_entry(31, {op_halt, 12'h000}, 1'b0);
        set_entry(32, nop_w, 1'b0);
        set_entry(33, nop_w, 1'b0);
        for (int i = 0; i < prog_len; i++) begin
            if (prog[i].rand_imm) begin
                draw_imm6(r);
                prog[i].instr[5:0] = r;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // architectural model, walks the table in program order
    task automatic run_model();
        logic [15:0] regs [8];
        logic [15:0] dmem [64];
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm;
        logic [15:0] res;
        logic [15:0] addr;
        int          pc;
        int          next_pc;
        int          off;
        int          steps;
        bit          done;
        for (int k = 0; k < 8; k++) begin
            regs[k] = '0;
        end
        for (int k = 0; k < 64; k++) begin
            dmem[k] = '0;
        end
        expect_q.delete();
        pc    = 0;
        steps = 0;
        done  = 1'b0;
        while (!done && pc >= 0 && pc < prog_len && steps < 4 * prog_len) begin
            w       = prog[pc].instr;
            a       = regs[w[8:6]];
            b       = regs[w[5:3]];
            imm     = {{10{w[5]}}, w[5:0]};
            off     = int'($signed(imm));
            addr    = a + imm;
            res     = '0;
            next_pc = pc + 1;
            prog[pc].wr_reg = w[11:9];
            case (w[15:12])
                op_rtype: begin
                    prog[pc].wr_en = 1'b1;
                    case (w[2:0])
                        fn_sub:  res = a - b;
                        fn_and:  res = a & b;
                        fn_xor:  res = a ^ b;
                        fn_slt:  res = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
                        default: res = a + b;
                    endcase
                end
                op_addi: begin
                    prog[pc].wr_en = 1'b1;
                    res = a + imm;
                end
                op_ld: begin
                    prog[pc].wr_en = 1'b1;
                    res = dmem[addr[5:0]];
                end
                op_st:   dmem[addr[5:0]] = regs[w[11:9]];
                op_beqz: next_pc = (a == '0) ? pc + 1 + off : pc + 1;
                op_bnez: next_pc = (a != '0) ? pc + 1 + off : pc + 1;
                op_halt: begin
                    prog[pc].halt = 1'b1;
                    done = 1'b1;
                end
                default: ;
            endcase
            if (prog[pc].wr_en) begin
                regs[w[11:9]]    = res;
                prog[pc].wr_data = res;
            end
            expect_q.push_back(pc);
            pc = next_pc;
            steps++;
        end
    endtask

    // program goes in while reset is up, reset stays 16 cycles past the last word
    task automatic load_and_reset();
        reset = 1'b1;
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clk);
            imem_we   = 1'b1;
            imem_addr = i[imem_aw-1:0];
            imem_data = prog[i].instr;
        end
        @(negedge clk);
        imem_we = 1'b0;
        repeat (reset_hold - 1) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic check_retire(input int idx);
        compare($sformatf("retire.wr_en @%0d", idx), 16'(retire.wr_en), 16'(prog[idx].wr_en));
        compare($sformatf("retire.halt @%0d", idx), 16'(retire.halt), 16'(prog[idx].halt));
        if (prog[idx].wr_en) begin
            compare($sformatf("retire.wr_reg @%0d", idx), 16'(retire.wr_reg),
                    16'(prog[idx].wr_reg));
            compare($sformatf("retire.wr_data @%0d", idx), retire.wb_data, prog[idx].wr_data);
        end
    endtask

    task automatic run_program(input logic with_illegal, input string name);
        int cycles;
        int seen;
        int errors_before;
        int idx;
        bit halted;
        errors_before = errors;
        build_program(with_illegal);
        run_model();
        load_and_reset();
        cycles = 0;
        seen   = 0;
        halted = 1'b0;
        while (!halted && cycles < timeout_cyc) begin
            @(negedge clk);
            cycles++;
            if (retire.valid) begin
                seen++;
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("%s: an instruction retired past the end of the program", name);
                end else begin
                    idx = expect_q.pop_front();
                    check_retire(idx);
                end
                halted = retire.halt;
            end
        end
        if (!halted) begin
            errors++;
            $display("%s: halt never retired within %0d cycles", name, timeout_cyc);
        end else begin
            compare("err", 16'(err), 16'(with_illegal));
            if (expect_q.size() != 0) begin
                errors++;
                $display("%s: halt retired with %0d instructions still missing",
                         name, expect_q.size());
            end
            // nothing may retire after the halt
            repeat (quiet_cyc) begin
                @(negedge clk);
                if (retire.valid) begin
                    errors++;
                    $display("%s: an instruction retired after the halt", name);
                end
            end
        end
        $display("%s: %0d retires seen, %0d errors", name, seen, errors - errors_before);
    endtask

    initial begin
        reset     = 1'b1;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        errors    = 0;
        checks    = 0;
        lfsr      = 32'he6c8;
        run_program(1'b1, "run 1, undefined opcode present");
        run_program(1'b0, "run 2, no undefined opcode");
        $display("%0d compares, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/proc.sv ====
// five-stage pipeline top level, wiring the four stage blocks together
module proc
    import proc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  imem_we,
    input  logic [imem_aw-1:0]    imem_addr,
    input  logic [data_width-1:0] imem_data,
    output retire_t               retire,
    output logic                  err
);

    //////////////////////////////////////////////////
    // stage records
    if_id_t                if_id;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;

    // control back to fetch
    logic                  redirect;
    logic [data_width-1:0] redirect_pc;
    logic                  halting;

    fetch fetch0 (
        .clk         (clk),
        .reset       (reset),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halting     (halting),
        .if_id       (if_id)
    );

    // a taken branch also kills the word in decode
    decode decode0 (
        .clk   (clk),
        .reset (reset),
        .if_id (if_id),
        .flush (redirect),
        .wb    (retire),
        .id_ex (id_ex),
        .err   (err)
    );

    execute execute0 (
        .clk         (clk),
        .reset       (reset),
        .id_ex       (id_ex),
        .ex_mem      (ex_mem),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory memory0 (
        .clk     (clk),
        .reset   (reset),
        .ex_mem  (ex_mem),
        .wb      (retire),
        .halting (halting)
    );

endmodule

// ==== hdl/memory.sv ====
// memory stage with word-addressed data memory and the MEM/WB register
module memory
    import proc_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  ex_mem_t ex_mem,
    output mem_wb_t wb,
    output logic    halting
);

    logic [data_width-1:0] dmem [dmem_depth];
    logic [dmem_aw-1:0]    daddr;
    logic [data_width-1:0] load_data;

    assign daddr     = ex_mem.alu_out[dmem_aw-1:0];
    assign load_data = dmem[daddr];

    // cleared on reset so unwritten words read as zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < dmem_depth; k++) begin
                dmem[k] <= '0;
            end
        end else if (ex_mem.valid && ex_mem.mem_write) begin
            dmem[daddr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk) begin
        wb.wb_data <= ex_mem.mem_read ? load_data : ex_mem.alu_out;
        wb.halt    <= ex_mem.halt;
        wb.wr_en   <= ex_mem.wr_en;
        wb.wr_reg  <= ex_mem.wr_reg;
        wb.valid   <= reset ? 1'b0 : ex_mem.valid;
    end

    assign halting = ex_mem.valid && ex_mem.halt;

endmodule

// ==== hdl/execute.sv ====
// execute stage with ALU, branch resolution and the EX/MEM register
module execute
    import proc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  id_ex_t                id_ex,
    output ex_mem_t               ex_mem,
    output logic                  redirect,
    output logic [data_width-1:0] redirect_pc
);

    logic [data_width-1:0] b_op;
    logic [data_width-1:0] alu_out;
    logic                  less;
    logic                  a_zero;

    assign b_op = id_ex.use_imm ? id_ex.imm : id_ex.b;
    assign less = $signed(id_ex.a) < $signed(b_op);

    always_comb begin
        case (id_ex.alu_op)
            alu_add: alu_out = id_ex.a + b_op;
            alu_sub: alu_out = id_ex.a - b_op;
            alu_and: alu_out = id_ex.a & b_op;
            alu_xor: alu_out = id_ex.a ^ b_op;
            alu_slt: alu_out = {{(data_width - 1){1'b0}}, less};
            default: alu_out = id_ex.a + b_op;
        endcase
    end

    //////////////////////////////////////////////////
    // branch resolution, target is word offset from pc_plus
    assign a_zero   = (id_ex.a == '0);
    assign redirect = id_ex.valid &&
                      ((id_ex.branch_zero && a_zero) || (id_ex.branch_nonzero && !a_zero));
    assign redirect_pc = id_ex.pc_plus + id_ex.imm;

    always_ff @(posedge clk) begin
        ex_mem.alu_out    <= alu_out;
        ex_mem.store_data <= id_ex.b;
        ex_mem.mem_read   <= id_ex.mem_read;
        ex_mem.mem_write  <= id_ex.mem_write;
        ex_mem.halt       <= id_ex.halt;
        ex_mem.wr_en      <= id_ex.wr_en;
        ex_mem.wr_reg     <= id_ex.wr_reg;
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
        end
    end

    // decode never marks an op as both load and store
    a_mem_op_onehot: assert property (
        @(posedge clk) disable iff (reset) id_ex.valid |-> !(id_ex.mem_read && id_ex.mem_write)
    );

endmodule

// ==== hdl/decode.sv ====
// decode stage with register file, immediate extension, ID/EX register and opcode check
module decode
    import proc_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  if_id_t  if_id,
    input  logic    flush,
    input  mem_wb_t wb,
    output id_ex_t  id_ex,
    output logic    err
);

    logic [data_width-1:0] regs [reg_count];
    logic [3:0]            opcode;
    logic [reg_aw-1:0]     a_idx;
    logic [reg_aw-1:0]     b_idx;
    logic                  wb_write;
    logic [data_width-1:0] a_data;
    logic [data_width-1:0] b_data;
    logic [data_width-1:0] imm_ext;
    logic                  illegal;
    id_ex_t                dec;

    assign opcode = if_id.instr.rtype.opcode;
    assign a_idx  = if_id.instr.rtype.rs;
    // a store reads its data through rd
    assign b_idx  = (opcode == op_st) ? if_id.instr.itype.rd : if_id.instr.rtype.rt;

    //////////////////////////////////////////////////
    // register file, r0 is an ordinary register
    assign wb_write = wb.valid && wb.wr_en;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < reg_count; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_write) begin
            regs[wb.wr_reg] <= wb.wb_data;
        end
    end

    // write-back value bypasses the array in the same cycle
    assign a_data = (wb_write && wb.wr_reg == a_idx) ? wb.wb_data : regs[a_idx];
    assign b_data = (wb_write && wb.wr_reg == b_idx) ? wb.wb_data : regs[b_idx];

    assign imm_ext = {{(data_width - 6){if_id.instr.itype.imm6[5]}}, if_id.instr.itype.imm6};

    //////////////////////////////////////////////////
    // control decode
    always_comb begin
        dec         = '0;
        dec.valid   = if_id.valid;
        dec.pc_plus = if_id.pc_plus;
        dec.a       = a_data;
        dec.b       = b_data;
        dec.imm     = imm_ext;
        dec.alu_op  = alu_add;
        dec.wr_reg  = if_id.instr.itype.rd;
        illegal     = 1'b0;
        case (opcode)
            op_rtype: begin
                dec.wr_en = 1'b1;
                case (if_id.instr.rtype.funct)
                    fn_add:  dec.alu_op = alu_add;
                    fn_sub:  dec.alu_op = alu_sub;
                    fn_and:  dec.alu_op = alu_and;
                    fn_xor:  dec.alu_op = alu_xor;
                    fn_slt:  dec.alu_op = alu_slt;
                    default: dec.alu_op = alu_add;
                endcase
            end
            op_addi: begin
                dec.use_imm = 1'b1;
                dec.wr_en   = 1'b1;
            end
            op_ld: begin
                dec.use_imm  = 1'b1;
                dec.mem_read = 1'b1;
                dec.wr_en    = 1'b1;
            end
            op_st: begin
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
            end
            op_beqz: dec.branch_zero    = 1'b1;
            op_bnez: dec.branch_nonzero = 1'b1;
            op_halt: dec.halt           = 1'b1;
            op_nop: begin
            end
            // undefined words flow on like a nop
            default: illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        id_ex <= dec;
        if (reset || flush) begin
            id_ex.valid <= 1'b0;
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            err <= 1'b0;
        end else if (if_id.valid && !flush && illegal) begin
            err <= 1'b1;
        end
    end

    a_wr_reg_in_range: assert property (
        @(posedge clk) disable iff (reset)
        wb_write |-> !$isunknown(wb.wr_reg) && (int'(wb.wr_reg) < reg_count)
    );

endmodule

// ==== hdl/fetch.sv ====
// fetch stage with pc, loadable instruction memory and the IF/ID register
module fetch
    import proc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  imem_we,
    input  logic [imem_aw-1:0]    imem_addr,
    input  logic [data_width-1:0] imem_data,
    input  logic                  redirect,
    input  logic [data_width-1:0] redirect_pc,
    input  logic                  halting,
    output if_id_t                if_id
);

    logic [data_width-1:0] imem [imem_depth];
    logic [data_width-1:0] pc;
    logic [data_width-1:0] pc_plus;
    instr_u                fetched;
    logic                  stopped;
    logic                  halted;
    logic                  freeze;

    // load port, one word per cycle
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_data;
        end
    end

    assign fetched = imem[pc[imem_aw-1:0]];
    assign pc_plus = pc + 1'b1;

    // stopped: a halt went out, no more fetches unless a branch takes us elsewhere
    // halted: the halt reached memory, nothing can redirect any more
    assign freeze = stopped || halted;

    always_ff @(posedge clk) begin
        if_id.pc_plus <= pc_plus;
        if_id.instr   <= fetched;
        if (reset) begin
            pc          <= '0;
            stopped     <= 1'b0;
            halted      <= 1'b0;
            if_id.valid <= 1'b0;
        end else begin
            if (halting) begin
                halted <= 1'b1;
            end
            if (redirect) begin
                // wrong-path word in flight is dropped
                pc          <= redirect_pc;
                stopped     <= 1'b0;
                if_id.valid <= 1'b0;
            end else if (freeze) begin
                if_id.valid <= 1'b0;
            end else begin
                pc          <= pc_plus;
                stopped     <= (fetched.rtype.opcode == op_halt);
                if_id.valid <= 1'b1;
            end
        end
    end

    // all branches are older than the halt, so none can be taken once it is in memory
    a_no_redirect_on_halt: assert property (
        @(posedge clk) disable iff (reset) halting |-> !redirect
    );

endmodule

// ==== hdl/proc_pkg.sv ====
// pipeline package with word sizes, opcodes, instruction views and stage records
package proc_pkg;

    localparam int data_width = 16;
    localparam int reg_count  = 8;
    localparam int imem_depth = 64;
    localparam int dmem_depth = 64;
    localparam int reg_aw     = $clog2(reg_count);
    localparam int imem_aw    = $clog2(imem_depth);
    localparam int dmem_aw    = $clog2(dmem_depth);

    //////////////////////////////////////////////////
    // opcodes, 4'h8 and above are undefined
    localparam logic [3:0] op_rtype = 4'h0;
    localparam logic [3:0] op_addi  = 4'h1;
    localparam logic [3:0] op_ld    = 4'h2;
    localparam logic [3:0] op_st    = 4'h3;
    localparam logic [3:0] op_beqz  = 4'h4;
    localparam logic [3:0] op_bnez  = 4'h5;
    localparam logic [3:0] op_halt  = 4'h6;
    localparam logic [3:0] op_nop   = 4'h7;

    // funct field of register-register ops
    localparam logic [2:0] fn_add = 3'd0;
    localparam logic [2:0] fn_sub = 3'd1;
    localparam logic [2:0] fn_and = 3'd2;
    localparam logic [2:0] fn_xor = 3'd3;
    localparam logic [2:0] fn_slt = 3'd4;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_xor,
        alu_slt
    } alu_op_e;

    //////////////////////////////////////////////////
    // instruction word, two views of the same 16 bits
    typedef struct packed {
        logic [3:0]        opcode;
        logic [reg_aw-1:0] rd;
        logic [reg_aw-1:0] rs;
        logic [reg_aw-1:0] rt;
        logic [2:0]        funct;
    } rtype_t;

    // store: rd is the data source; branch: rs is tested
    typedef struct packed {
        logic [3:0]        opcode;
        logic [reg_aw-1:0] rd;
        logic [reg_aw-1:0] rs;
        logic [5:0]        imm6;
    } itype_t;

    typedef union packed {
        rtype_t rtype;
        itype_t itype;
    } instr_u;

    //////////////////////////////////////////////////
    // stage registers
    typedef struct packed {
        logic                  valid;
        logic [data_width-1:0] pc_plus;
        instr_u                instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [data_width-1:0] pc_plus;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        logic [data_width-1:0] imm;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic                  mem_read;
        logic                  mem_write;
        logic                  branch_zero;
        logic                  branch_nonzero;
        logic                  halt;
        logic                  wr_en;
        logic [reg_aw-1:0]     wr_reg;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [data_width-1:0] alu_out;
        logic [data_width-1:0] store_data;
        logic                  mem_read;
        logic                  mem_write;
        logic                  halt;
        logic                  wr_en;
        logic [reg_aw-1:0]     wr_reg;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic                  halt;
        logic                  wr_en;
        logic [reg_aw-1:0]     wr_reg;
        logic [data_width-1:0] wb_data;
    } mem_wb_t;

    // what leaves the top level is the write-back record itself
    typedef mem_wb_t retire_t;

endpackage
